/* src/reset_support_pkg.sv */
// reset support package
// shared constants, state encodings and bundled signals for the
// button debouncer, the main reset sequencer and the CPU boot sequencer

package reset_support_pkg;

   // flops between the raw button pin and the debounce history
   localparam int SYNC_STAGES = 2;

   // consecutive high samples before a press is believed
   localparam int DEBOUNCE_LEN = 10;

   // length of the CPU reset pulse in clock cycles
   localparam int CPU_RESET_CYCLES = 3;

   // main sequencer states
   typedef enum logic [2:0]
   {
      ST_INIT         = 3'd0,
      ST_IDLE         = 3'd1,
      ST_PLL_RESET    = 3'd2,
      ST_REQUEST      = 3'd3,
      ST_WAIT_RELEASE = 3'd4
   } main_state_e;

   // CPU sequencer states
   // reset states are kept contiguous, boot follows the last of them
   typedef enum logic [2:0]
   {
      CPU_IDLE   = 3'd0,
      CPU_RESET1 = 3'd1,
      CPU_RESET2 = 3'd2,
      CPU_RESET3 = 3'd3,
      CPU_BOOT   = 3'd4
   } cpu_state_e;

   // debounced reset button
   typedef struct packed
   {
      logic level;
      logic pressed;
   } button_evt_t;

   // CPU control lines
   typedef struct packed
   {
      logic reset;
      logic boot;
   } cpu_ctl_t;

endpackage

/* src/button_debouncer.sv */
// reset button debouncer
// brings the raw button into the clock domain, filters out contact
// bounce and reports a debounced level and a one-cycle press event

module button_debouncer
(
   input  logic                           sys_slowclk,
   input  logic                           dcm_reset,
   input  logic                           button_r,
   output reset_support_pkg::button_evt_t button_evt
);

   import reset_support_pkg::*;

   logic [SYNC_STAGES-1:0]  sync_q;
   logic [DEBOUNCE_LEN-1:0] history_q;
   logic [DEBOUNCE_LEN-1:0] history_next;
   logic                    history_full;
   logic                    level_prev_q;
   logic                    pressed_q;

   // synchronizer chain with the newest sample in bit 0
   always_ff @(posedge sys_slowclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         sync_q <= '0;
      end
      else
      begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], button_r};
      end
   end

   // history gets the synchronized sample shifted in every cycle
   assign history_next = {history_q[DEBOUNCE_LEN-2:0], sync_q[SYNC_STAGES-1]};

   always_ff @(posedge sys_slowclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         history_q <= '0;
      end
      else
      begin
         history_q <= history_next;
      end
   end

   // level high only while every stored sample is high
   assign history_full = &history_q;

   // press event in the cycle after the level rises
   always_ff @(posedge sys_slowclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         level_prev_q <= 1'b0;
         pressed_q    <= 1'b0;
      end
      else
      begin
         level_prev_q <= history_full;
         pressed_q    <= history_full & ~level_prev_q;
      end
   end

   assign button_evt = '{level: history_full, pressed: pressed_q};

endmodule

/* src/reset_sequencer.sv */
// main reset sequencer
// runs the reset sequence after power-on and after each debounced
// press: one-cycle clock manager reset, then a request to the CPU side,
// then holds off further presses until the button is let go

module reset_sequencer
(
   input  logic                           sys_slowclk,
   input  logic                           dcm_reset,
   input  reset_support_pkg::button_evt_t button_evt,
   input  logic                           reset_req_ready,
   output logic                           reset_req_valid,
   output logic                           pll_reset
);

   import reset_support_pkg::*;

   main_state_e state_q;
   main_state_e state_next;
   logic        req_fire;

   // request moves across on an edge where both sides agree
   assign req_fire = reset_req_valid & reset_req_ready;

   always_ff @(posedge sys_slowclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         state_q <= ST_INIT;
      end
      else
      begin
         state_q <= state_next;
      end
   end

   always_comb
   begin
      state_next = state_q;
      unique case (state_q)
         ST_INIT:
         begin
            // power-on always kicks off a full sequence
            state_next = ST_PLL_RESET;
         end
         ST_IDLE:
         begin
            if (button_evt.pressed)
            begin
               state_next = ST_PLL_RESET;
            end
         end
         ST_PLL_RESET:
         begin
            state_next = ST_REQUEST;
         end
         ST_REQUEST:
         begin
            // stay here with valid up while the CPU side is busy
            if (req_fire)
            begin
               state_next = ST_WAIT_RELEASE;
            end
         end
         ST_WAIT_RELEASE:
         begin
            // presses seen here are dropped
            if (!button_evt.level)
            begin
               state_next = ST_IDLE;
            end
         end
         default:
         begin
            state_next = ST_INIT;
         end
      endcase
   end

   // outputs straight from the state register
   assign pll_reset       = (state_q == ST_PLL_RESET);
   assign reset_req_valid = (state_q == ST_REQUEST);

endmodule

/* src/cpu_boot_sequencer.sv */
// CPU boot sequencer
// takes one reset request while idle and walks the CPU through a fixed
// reset pulse, with the boot line over the last reset cycle and one more

module cpu_boot_sequencer
(
   input  logic                        sys_slowclk,
   input  logic                        dcm_reset,
   input  logic                        reset_req_valid,
   output logic                        reset_req_ready,
   output reset_support_pkg::cpu_ctl_t cpu_ctl
);

   import reset_support_pkg::*;

   cpu_state_e state_q;
   cpu_state_e state_next;
   logic       req_fire;
   logic       in_reset;
   logic       in_boot;

   assign req_fire = reset_req_valid & reset_req_ready;

   always_ff @(posedge sys_slowclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         state_q <= CPU_IDLE;
      end
      else
      begin
         state_q <= state_next;
      end
   end

   always_comb
   begin
      state_next = state_q;
      unique case (state_q)
         CPU_IDLE:
         begin
            if (req_fire)
            begin
               state_next = CPU_RESET1;
            end
         end
         CPU_RESET1:
         begin
            state_next = CPU_RESET2;
         end
         CPU_RESET2:
         begin
            state_next = CPU_RESET3;
         end
         CPU_RESET3:
         begin
            state_next = CPU_BOOT;
         end
         CPU_BOOT:
         begin
            state_next = CPU_IDLE;
         end
         default:
         begin
            state_next = CPU_IDLE;
         end
      endcase
   end

   // reset states run from CPU_RESET1 for CPU_RESET_CYCLES codes
   assign in_reset = (state_q >= CPU_RESET1) &&
                     (int'(state_q) < int'(CPU_RESET1) + CPU_RESET_CYCLES);

   // boot overlaps the final reset cycle, then holds one more
   assign in_boot = (int'(state_q) == int'(CPU_RESET1) + CPU_RESET_CYCLES - 1) ||
                    (state_q == CPU_BOOT);

   assign reset_req_ready = (state_q == CPU_IDLE);
   assign cpu_ctl         = '{reset: in_reset, boot: in_boot};

endmodule

/* src/reset_support_top.sv */
// reset and boot support
// debounced reset button feeding the main reset sequencer, which hands
// CPU resets to the CPU boot sequencer over a valid/ready request

module reset_support_top
(
   input  logic                        sys_slowclk,
   input  logic                        dcm_reset,
   input  logic                        button_r,
   output logic                        pll_reset,
   output reset_support_pkg::cpu_ctl_t cpu_ctl
);

   import reset_support_pkg::*;

   button_evt_t button_evt;
   logic        reset_req_valid;
   logic        reset_req_ready;

   button_debouncer u_button_debouncer
   (
      .sys_slowclk (sys_slowclk),
      .dcm_reset   (dcm_reset),
      .button_r    (button_r),
      .button_evt  (button_evt)
   );

   reset_sequencer u_reset_sequencer
   (
      .sys_slowclk     (sys_slowclk),
      .dcm_reset       (dcm_reset),
      .button_evt      (button_evt),
      .reset_req_ready (reset_req_ready),
      .reset_req_valid (reset_req_valid),
      .pll_reset       (pll_reset)
   );

   cpu_boot_sequencer u_cpu_boot_sequencer
   (
      .sys_slowclk     (sys_slowclk),
      .dcm_reset       (dcm_reset),
      .reset_req_valid (reset_req_valid),
      .reset_req_ready (reset_req_ready),
      .cpu_ctl         (cpu_ctl)
   );

endmodule

/* test/reset_support_properties.sv */
// reset support properties
// timing rules on the clock manager reset and the CPU control lines

module reset_support_properties
(
   input logic                        sys_slowclk,
   input logic                        dcm_reset,
   input logic                        pll_reset,
   input reset_support_pkg::cpu_ctl_t cpu_ctl
);

   import reset_support_pkg::*;

   // one-cycle clock manager pulse
   assert property (@(posedge sys_slowclk) disable iff (dcm_reset)
      pll_reset |=> !pll_reset)
      else $error("pll_reset high for two cycles");

   assert property (@(posedge sys_slowclk) disable iff (dcm_reset)
      $rose(cpu_ctl.boot) |-> cpu_ctl.reset)
      else $error("boot rose outside CPU reset");

   // reset pulse length
   assert property (@(posedge sys_slowclk) disable iff (dcm_reset)
      $rose(cpu_ctl.reset) |-> cpu_ctl.reset [*CPU_RESET_CYCLES] ##1 !cpu_ctl.reset)
      else $error("CPU reset pulse has wrong length");

   assert property (@(posedge sys_slowclk) disable iff (dcm_reset)
      !(pll_reset && cpu_ctl.reset))
      else $error("pll_reset overlaps CPU reset");

endmodule

bind reset_support_top reset_support_properties u_properties
(
   .sys_slowclk (sys_slowclk),
   .dcm_reset   (dcm_reset),
   .pll_reset   (pll_reset),
   .cpu_ctl     (cpu_ctl)
);

/* test/reset_support_tb.sv */
// reset support testbench
// random button stimulus against a cycle model of debouncer and sequencers

module reset_support_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import reset_support_pkg::*;

   logic sys_slowclk;
   logic dcm_reset;
   logic button_r;
   logic pll_reset;
   cpu_ctl_t cpu_ctl;

   logic [31:0] seed = 32'h0c27_eacc;
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int pll_pulses = 0;

   // model state
   logic [SYNC_STAGES-1:0] m_sync;
   int m_run;
   logic m_level;
   logic m_level_d;
   logic m_pressed;
   int m_main;  // 0 init, 1 idle, 2 pll, 3 request, 4 wait release
   int m_cpu;   // 0 idle, 1..3 reset, 4 boot

   reset_support_top dut
   (
      .sys_slowclk (sys_slowclk),
      .dcm_reset   (dcm_reset),
      .button_r    (button_r),
      .pll_reset   (pll_reset),
      .cpu_ctl     (cpu_ctl)
   );

   initial
   begin
      sys_slowclk = 1'b0;
      forever #20 sys_slowclk = ~sys_slowclk;
   end

   always @(posedge sys_slowclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         m_sync <= '0;
         m_run <= 0;
         m_level <= 1'b0;
         m_level_d <= 1'b0;
         m_pressed <= 1'b0;
         m_main <= 0;
         m_cpu <= 0;
      end
      else
      begin
         m_sync <= {m_sync[SYNC_STAGES-2:0], button_r};
         m_run <= m_sync[SYNC_STAGES-1] ? ((m_run < 1000) ? m_run + 1 : m_run) : 0;
         m_level <= m_sync[SYNC_STAGES-1] && (m_run + 1 >= DEBOUNCE_LEN);
         m_level_d <= m_level;
         m_pressed <= m_level && !m_level_d;
         case (m_main)
            0: m_main <= 2;
            1: if (m_pressed) m_main <= 2;
            2: m_main <= 3;
            3: if (m_cpu == 0) m_main <= 4;
            default: if (!m_level) m_main <= 1;
         endcase
         if (m_cpu == 0 && m_main == 3)
            m_cpu <= 1;
         else if (m_cpu != 0)
            m_cpu <= (m_cpu == 4) ? 0 : m_cpu + 1;
      end
   end

   function automatic int next_rand(int lo, int hi);
      seed = seed * 32'd1664525 + 32'd1013904223;
      return lo + int'((seed >> 16) % (hi - lo + 1));
   endfunction

   task automatic check_value(string name, logic actual, logic expected);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns %s: got %0b expected %0b", $time, name, actual, expected);
         errors++;
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge sys_slowclk)
   begin
      check_value("pll_reset", pll_reset, m_main == 2);
      check_value("cpu_ctl.reset", cpu_ctl.reset, m_cpu >= 1 && m_cpu <= 3);
      check_value("cpu_ctl.boot", cpu_ctl.boot, m_cpu == 3 || m_cpu == 4);
      if (pll_reset)
         pll_pulses++;
   end

   task automatic drive_run(logic value, int len);
      for (int i = 0; i < len; i++)
      begin
         @(posedge sys_slowclk);
         button_r <= value;
      end
   endtask

   task automatic wait_idle(string what);
      int n;
      n = 0;
      while (!(m_main == 1 && m_cpu == 0) && n < 300)
      begin
         @(posedge sys_slowclk);
         n++;
      end
      if (n >= 300)
      begin
         $display("timeout: %s never returned to idle", what);
         errors++;
      end
   endtask

   task automatic finish_test(string name, int errs_before, int pulses_before, int want);
      if (pll_pulses - pulses_before != want)
      begin
         $display("[FAIL] %0t ns %s reset sequences: got %0d expected %0d", $time, name,
                  pll_pulses - pulses_before, want);
         errors++;
      end
      tests_run++;
      if (errors != errs_before)
         tests_failed++;
      $display("test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
   endtask

   task automatic pulse_reset();
      @(posedge sys_slowclk);
      dcm_reset <= 1'b1;
      repeat (2) @(posedge sys_slowclk);
      dcm_reset <= 1'b0;
   endtask

   initial
   begin
      int e;
      int p;
      int n;
      dcm_reset = 1'b1;
      button_r = 1'b0;

      e = errors;
      p = pll_pulses;
      pulse_reset();
      wait_idle("power-on");
      finish_test("power_on", e, p, 1);

      e = errors;
      p = pll_pulses;
      for (int i = 0; i < 30; i++)
      begin
         drive_run(1'b1, next_rand(1, 8));
         drive_run(1'b0, next_rand(1, 8));
      end
      drive_run(1'b0, 20);
      finish_test("bounce", e, p, 0);

      e = errors;
      p = pll_pulses;
      for (int i = 0; i < 5; i++)
      begin
         drive_run(1'b1, next_rand(15, 60));
         drive_run(1'b0, 20);
         wait_idle("press");
      end
      finish_test("press", e, p, 5);

      e = errors;
      p = pll_pulses;
      drive_run(1'b1, 200);
      drive_run(1'b0, 20);
      drive_run(1'b1, next_rand(15, 60));
      drive_run(1'b0, 20);
      wait_idle("held button");
      finish_test("held", e, p, 2);

      // press and hold until the CPU reset is under way
      e = errors;
      p = pll_pulses;
      @(posedge sys_slowclk);
      button_r <= 1'b1;
      n = 0;
      while (!cpu_ctl.reset && n < 100)
      begin
         @(posedge sys_slowclk);
         n++;
      end
      if (n >= 100)
      begin
         $display("timeout: CPU reset never started before mid-sequence reset");
         errors++;
      end
      dcm_reset <= 1'b1;
      button_r <= 1'b0;
      #1;
      check_value("pll_reset", pll_reset, 1'b0);
      check_value("cpu_ctl.reset", cpu_ctl.reset, 1'b0);
      check_value("cpu_ctl.boot", cpu_ctl.boot, 1'b0);
      @(posedge sys_slowclk);
      dcm_reset <= 1'b0;
      wait_idle("mid-sequence reset");
      finish_test("mid_reset", e, p, 2);

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial
   begin
      #2ms;
      $display("run did not complete within its time limit");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* src.f */
src/reset_support_pkg.sv
src/button_debouncer.sv
src/reset_sequencer.sv
src/cpu_boot_sequencer.sv
src/reset_support_top.sv
test/reset_support_properties.sv
test/reset_support_tb.sv

/* run.sh */
#!/bin/sh
# build and run the reset support testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall \
   --top-module reset_support_tb \
   -f src.f \
   -o reset_support_sim

./obj_dir/reset_support_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
   exit 1
fi
